//--- src/exec_pkg.sv
`default_nettype none

package exec_pkg;

    ////////////////////////////////
    // widths
    ////////////////////////////////

    // data width that the word forms are built around
    localparam int XLEN = 64;

    // register index width on every port
    localparam int REG_ADDR_W = 5;

    ////////////////////////////////
    // encodings
    ////////////////////////////////

    typedef enum logic [4:0] {
        OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_XOR, OP_OR, OP_AND,
        OP_SLL, OP_SRL, OP_SRA,
        OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
        OP_DIV, OP_DIVU, OP_REM, OP_REMU
    } alu_op_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_ALU,
        S_MULDIV_WAIT,
        S_ACK,
        S_RELEASE
    } seq_state_e;

    // everything from mul onward runs in the iterative unit
    function automatic logic is_muldiv_op(alu_op_e op);
        return op inside {[OP_MUL:OP_REMU]};
    endfunction

    // ops with a 32-bit form (addw, subw, ..., remuw)
    function automatic logic has_word_form(alu_op_e op);
        return op inside {OP_ADD, OP_SUB, OP_SLL, OP_SRL, OP_SRA,
                          OP_MUL, OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    endfunction

endpackage

`default_nettype wire

//--- src/int_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module int_regfile #(
    parameter int REG_COUNT = 32
) (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire  [exec_pkg::REG_ADDR_W-1:0]     rs1_addr,
    input  wire  [exec_pkg::REG_ADDR_W-1:0]     rs2_addr,
    input  wire                                 we,
    input  wire  [exec_pkg::REG_ADDR_W-1:0]     waddr,
    input  wire  [exec_pkg::XLEN-1:0]           wdata,
    output logic [exec_pkg::XLEN-1:0]           rs1_data,
    output logic [exec_pkg::XLEN-1:0]           rs2_data
);

    logic [exec_pkg::XLEN-1:0] regs [REG_COUNT];

    // x0 never written, so it stays at the reset value
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0 && int'(waddr) < REG_COUNT) begin
            regs[waddr] <= wdata;
        end
    end

    // out of range indices read as zero
    assign rs1_data = (int'(rs1_addr) < REG_COUNT) ? regs[rs1_addr] : '0;
    assign rs2_data = (int'(rs2_addr) < REG_COUNT) ? regs[rs2_addr] : '0;

    // the sequencer filters rd == 0 before raising we
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (reset) we |-> waddr != '0
    ) else $error("write strobe with destination x0");

endmodule

`default_nettype wire

//--- src/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire  [exec_pkg::XLEN-1:0]   a,
    input  wire  [exec_pkg::XLEN-1:0]   b,
    input  wire  exec_pkg::alu_op_e     op,
    input  wire                         word,
    output logic [exec_pkg::XLEN-1:0]   alu_result
);

    logic                           use_sub;
    logic                           carry;
    logic [exec_pkg::XLEN-1:0]      adder_b;
    logic [exec_pkg::XLEN-1:0]      sum;
    logic                           slt_bit;
    logic [exec_pkg::XLEN-1:0]      shift_src;
    logic [exec_pkg::XLEN-1:0]      src_rev;
    logic [exec_pkg::XLEN-1:0]      shift_in;
    logic [exec_pkg::XLEN-1:0]      shifted;
    logic [exec_pkg::XLEN-1:0]      sll_res;
    logic [exec_pkg::XLEN-1:0]      sra_fill;
    logic [exec_pkg::XLEN-1:0]      sra_res;
    logic [5:0]                     shamt;
    logic [exec_pkg::XLEN-1:0]      full_res;

    //////////////////////////////
    // shared adder
    //////////////////////////////

    // sub and both compares run as a + ~b + 1
    assign use_sub = op inside {exec_pkg::OP_SUB, exec_pkg::OP_SLT, exec_pkg::OP_SLTU};
    assign adder_b = use_sub ? ~b : b;
    assign {carry, sum} = {1'b0, a} + {1'b0, adder_b} + {{exec_pkg::XLEN{1'b0}}, use_sub};

    // a negative a wins over a positive b and equal signs use the difference sign
    assign slt_bit = (a[exec_pkg::XLEN-1] & ~b[exec_pkg::XLEN-1])
                   | (~(a[exec_pkg::XLEN-1] ^ b[exec_pkg::XLEN-1]) & sum[exec_pkg::XLEN-1]);

    //////////////////////////////
    // shifter
    //////////////////////////////

    // word forms shift only the low half and sraw needs its sign in bit 63
    always_comb begin
        if (!word) begin
            shift_src = a;
        end else if (op == exec_pkg::OP_SRA) begin
            shift_src = {{32{a[31]}}, a[31:0]};
        end else begin
            shift_src = {32'b0, a[31:0]};
        end
    end

    assign shamt = word ? {1'b0, b[4:0]} : b[5:0];

    // sll goes through the one right shifter bit reversed
    assign src_rev  = {<<{shift_src}};
    assign shift_in = (op == exec_pkg::OP_SLL) ? src_rev : shift_src;
    assign shifted  = shift_in >> shamt;
    assign sll_res  = {<<{shifted}};

    assign sra_fill = ~({exec_pkg::XLEN{1'b1}} >> shamt);
    assign sra_res  = shifted | ({exec_pkg::XLEN{shift_in[exec_pkg::XLEN-1]}} & sra_fill);

    //////////////////////////////
    // result select
    //////////////////////////////

    always_comb begin
        case (op)
            exec_pkg::OP_ADD,
            exec_pkg::OP_SUB:  full_res = sum;
            exec_pkg::OP_SLT:  full_res = {{(exec_pkg::XLEN-1){1'b0}}, slt_bit};
            exec_pkg::OP_SLTU: full_res = {{(exec_pkg::XLEN-1){1'b0}}, ~carry};
            exec_pkg::OP_XOR:  full_res = a ^ b;
            exec_pkg::OP_OR:   full_res = a | b;
            exec_pkg::OP_AND:  full_res = a & b;
            exec_pkg::OP_SLL:  full_res = sll_res;
            exec_pkg::OP_SRL:  full_res = shifted;
            exec_pkg::OP_SRA:  full_res = sra_res;
            // mul/div opcodes belong to the iterative unit
            default:           full_res = '0;
        endcase
        alu_result = word ? {{32{full_res[31]}}, full_res[31:0]} : full_res;
    end

endmodule

`default_nettype wire

//--- src/muldiv_unit.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         start,
    input  wire  exec_pkg::alu_op_e     op,
    input  wire                         word,
    input  wire  [exec_pkg::XLEN-1:0]   a,
    input  wire  [exec_pkg::XLEN-1:0]   b,
    output logic                        done,
    output logic [exec_pkg::XLEN-1:0]   md_result
);

    typedef enum logic [1:0] {MD_IDLE, MD_RUN, MD_FIX} md_state_e;

    md_state_e                      state;
    logic [5:0]                     step;
    exec_pkg::alu_op_e              op_q;
    logic                           word_q;
    logic                           neg_q;
    logic                           neg_r;
    logic [exec_pkg::XLEN-1:0]      hi;
    logic [exec_pkg::XLEN-1:0]      lo;
    logic [exec_pkg::XLEN-1:0]      b_reg;
    logic                           div_op;
    logic                           run_div;
    logic                           a_neg;
    logic                           b_neg;
    logic                           div_zero;
    logic [exec_pkg::XLEN-1:0]      a_ext;
    logic [exec_pkg::XLEN-1:0]      b_ext;
    logic [exec_pkg::XLEN:0]        mul_sum;
    logic [exec_pkg::XLEN:0]        div_shift;
    logic [exec_pkg::XLEN:0]        div_diff;
    logic [2*exec_pkg::XLEN-1:0]    product;
    logic [exec_pkg::XLEN-1:0]      raw;

    ////////////////////////////////
    // operand prep on start
    ////////////////////////////////

    always_comb begin
        div_op = op inside {exec_pkg::OP_DIV, exec_pkg::OP_DIVU,
                            exec_pkg::OP_REM, exec_pkg::OP_REMU};
        if (!word) begin
            a_ext = a;
            b_ext = b;
        end else if (op inside {exec_pkg::OP_DIVU, exec_pkg::OP_REMU}) begin
            a_ext = {32'b0, a[31:0]};
            b_ext = {32'b0, b[31:0]};
        end else begin
            a_ext = {{32{a[31]}}, a[31:0]};
            b_ext = {{32{b[31]}}, b[31:0]};
        end
        a_neg = a_ext[exec_pkg::XLEN-1]
              & (op inside {exec_pkg::OP_MULH, exec_pkg::OP_MULHSU,
                            exec_pkg::OP_DIV, exec_pkg::OP_REM});
        b_neg = b_ext[exec_pkg::XLEN-1]
              & (op inside {exec_pkg::OP_MULH, exec_pkg::OP_DIV, exec_pkg::OP_REM});
        div_zero = div_op && b_ext == '0;
    end

    ////////////////////////////////
    // one step per cycle
    ////////////////////////////////

    assign run_div = op_q inside {exec_pkg::OP_DIV, exec_pkg::OP_DIVU,
                                  exec_pkg::OP_REM, exec_pkg::OP_REMU};

    // multiply accumulates in hi while the multiplier shifts out of lo
    assign mul_sum = lo[0] ? {1'b0, hi} + {1'b0, b_reg} : {1'b0, hi};

    // bit 64 of the divide difference is the borrow
    assign div_shift = {hi, lo[exec_pkg::XLEN-1]};
    assign div_diff  = div_shift - {1'b0, b_reg};

    // min / -1 comes out of the sign fix as min with rem 0
    always_comb begin
        product = neg_q ? -{hi, lo} : {hi, lo};
        case (op_q)
            exec_pkg::OP_MUL:    raw = product[exec_pkg::XLEN-1:0];
            exec_pkg::OP_MULH,
            exec_pkg::OP_MULHSU,
            exec_pkg::OP_MULHU:  raw = product[2*exec_pkg::XLEN-1:exec_pkg::XLEN];
            exec_pkg::OP_DIV,
            exec_pkg::OP_DIVU:   raw = neg_q ? -lo : lo;
            exec_pkg::OP_REM,
            exec_pkg::OP_REMU:   raw = neg_r ? -hi : hi;
            default:             raw = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= MD_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                MD_IDLE: if (start) state <= div_zero ? MD_FIX : MD_RUN;
                MD_RUN:  if (step == 6'd63) state <= MD_FIX;
                MD_FIX: begin
                    done  <= 1'b1;
                    state <= MD_IDLE;
                end
                default: state <= MD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            MD_IDLE: if (start) begin
                op_q   <= op;
                word_q <= word;
                step   <= '0;
                b_reg  <= b_neg ? -b_ext : b_ext;
                if (div_zero) begin
                    // quotient all ones, remainder is the dividend
                    hi    <= a_ext;
                    lo    <= '1;
                    neg_q <= 1'b0;
                    neg_r <= 1'b0;
                end else begin
                    hi    <= '0;
                    lo    <= a_neg ? -a_ext : a_ext;
                    neg_q <= a_neg ^ b_neg;
                    neg_r <= a_neg;
                end
            end
            MD_RUN: begin
                step <= step + 6'd1;
                if (!run_div) begin
                    {hi, lo} <= {mul_sum, lo[exec_pkg::XLEN-1:1]};
                end else if (!div_diff[exec_pkg::XLEN]) begin
                    hi <= div_diff[exec_pkg::XLEN-1:0];
                    lo <= {lo[exec_pkg::XLEN-2:0], 1'b1};
                end else begin
                    hi <= div_shift[exec_pkg::XLEN-1:0];
                    lo <= {lo[exec_pkg::XLEN-2:0], 1'b0};
                end
            end
            MD_FIX: md_result <= word_q ? {{32{raw[31]}}, raw[31:0]} : raw;
            default: ;
        endcase
    end

    a_start_idle: assert property (
        @(posedge clk) disable iff (reset) start |-> state == MD_IDLE
    ) else $error("start while multiply/divide busy");

    // any done must trace back to a start within the longest latency
    a_done_after_start: assert property (
        @(posedge clk) disable iff (reset) (!start)[*68] |-> !done
    ) else $error("done without a preceding start");

endmodule

`default_nettype wire

//--- src/exec_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module exec_sequencer #(
    parameter int REG_COUNT = 32
) (
    input  wire                                 clk,
    input  wire                                 reset,
    // command handshake
    input  wire                                 req,
    input  wire  exec_pkg::alu_op_e             op,
    input  wire                                 word,
    input  wire  [exec_pkg::REG_ADDR_W-1:0]     rd,
    input  wire  [exec_pkg::REG_ADDR_W-1:0]     rs1,
    input  wire  [exec_pkg::REG_ADDR_W-1:0]     rs2,
    input  wire                                 use_imm,
    input  wire  [exec_pkg::XLEN-1:0]           imm,
    output logic                                ack,
    output logic [exec_pkg::XLEN-1:0]           result,
    output logic                                error,
    // register file
    output logic [exec_pkg::REG_ADDR_W-1:0]     rs1_addr,
    output logic [exec_pkg::REG_ADDR_W-1:0]     rs2_addr,
    input  wire  [exec_pkg::XLEN-1:0]           rs1_data,
    input  wire  [exec_pkg::XLEN-1:0]           rs2_data,
    output logic                                we,
    output logic [exec_pkg::REG_ADDR_W-1:0]     waddr,
    output logic [exec_pkg::XLEN-1:0]           wdata,
    // alu
    output logic [exec_pkg::XLEN-1:0]           alu_a,
    output logic [exec_pkg::XLEN-1:0]           alu_b,
    output exec_pkg::alu_op_e                   alu_op,
    output logic                                alu_word,
    input  wire  [exec_pkg::XLEN-1:0]           alu_result,
    // multiply/divide
    output logic                                start,
    output exec_pkg::alu_op_e                   md_op,
    output logic                                md_word,
    output logic [exec_pkg::XLEN-1:0]           md_a,
    output logic [exec_pkg::XLEN-1:0]           md_b,
    input  wire                                 done,
    input  wire  [exec_pkg::XLEN-1:0]           md_result
);

    exec_pkg::seq_state_e               state;
    exec_pkg::alu_op_e                  op_q;
    logic                               word_q;
    logic                               use_imm_q;
    logic                               err_q;
    logic [exec_pkg::REG_ADDR_W-1:0]    rd_q;
    logic [exec_pkg::REG_ADDR_W-1:0]    rs1_q;
    logic [exec_pkg::REG_ADDR_W-1:0]    rs2_q;
    logic [exec_pkg::XLEN-1:0]          imm_q;
    logic [exec_pkg::XLEN-1:0]          operand_b;
    logic                               is_md;
    logic                               alu_wb;
    logic                               cmd_err;

    function automatic logic index_bad(input logic [exec_pkg::REG_ADDR_W-1:0] idx);
        return int'(idx) >= REG_COUNT;
    endfunction

    // bad index or a word flag on an op without a word form
    assign cmd_err = index_bad(rd) || index_bad(rs1) || (!use_imm && index_bad(rs2))
                  || (word && !exec_pkg::has_word_form(op));

    // command fields captured as req is accepted
    always_ff @(posedge clk) begin
        if (state == exec_pkg::S_IDLE && req) begin
            op_q      <= op;
            word_q    <= word;
            rd_q      <= rd;
            rs1_q     <= rs1;
            rs2_q     <= rs2;
            use_imm_q <= use_imm;
            imm_q     <= imm;
        end
    end

    ////////////////////////////////
    // FSM
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= exec_pkg::S_IDLE;
            ack    <= 1'b0;
            error  <= 1'b0;
            err_q  <= 1'b0;
            result <= '0;
        end else begin
            case (state)
                exec_pkg::S_IDLE: if (req) begin
                    err_q <= cmd_err;
                    state <= exec_pkg::S_ALU;
                end
                exec_pkg::S_ALU: if (is_md && !err_q) begin
                    state <= exec_pkg::S_MULDIV_WAIT;
                end else begin
                    result <= err_q ? '0 : alu_result;
                    error  <= err_q;
                    state  <= exec_pkg::S_ACK;
                end
                exec_pkg::S_MULDIV_WAIT: if (done) begin
                    result <= md_result;
                    error  <= 1'b0;
                    state  <= exec_pkg::S_ACK;
                end
                exec_pkg::S_ACK: begin
                    ack   <= 1'b1;
                    state <= exec_pkg::S_RELEASE;
                end
                // hold ack and result for as long as req stays up
                exec_pkg::S_RELEASE: if (!req) begin
                    ack   <= 1'b0;
                    error <= 1'b0;
                    state <= exec_pkg::S_IDLE;
                end
                default: state <= exec_pkg::S_IDLE;
            endcase
        end
    end

    ////////////////////////////////
    // datapath steering
    ////////////////////////////////

    assign is_md     = exec_pkg::is_muldiv_op(op_q);
    assign rs1_addr  = rs1_q;
    assign rs2_addr  = rs2_q;
    assign operand_b = use_imm_q ? imm_q : rs2_data;

    assign alu_a    = rs1_data;
    assign alu_b    = operand_b;
    assign alu_op   = op_q;
    assign alu_word = word_q;

    assign md_a    = rs1_data;
    assign md_b    = operand_b;
    assign md_op   = op_q;
    assign md_word = word_q;
    assign start   = state == exec_pkg::S_ALU && is_md && !err_q;

    // writes land one edge before ack rises
    assign alu_wb = state == exec_pkg::S_ALU && !is_md && !err_q;
    assign we     = (alu_wb || (state == exec_pkg::S_MULDIV_WAIT && done)) && rd_q != '0;
    assign waddr  = rd_q;
    assign wdata  = (state == exec_pkg::S_MULDIV_WAIT) ? md_result : alu_result;

    a_ack_hold: assert property (
        @(posedge clk) disable iff (reset) $fell(ack) |-> !$past(req)
    ) else $error("ack dropped while req still high");

endmodule

`default_nettype wire

//--- src/exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module exec_top #(
    parameter int REG_COUNT = 32
) (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire                                 req,
    input  wire  exec_pkg::alu_op_e             op,
    input  wire                                 word,
    input  wire  [exec_pkg::REG_ADDR_W-1:0]     rd,
    input  wire  [exec_pkg::REG_ADDR_W-1:0]     rs1,
    input  wire  [exec_pkg::REG_ADDR_W-1:0]     rs2,
    input  wire                                 use_imm,
    input  wire  [exec_pkg::XLEN-1:0]           imm,
    output logic                                ack,
    output logic [exec_pkg::XLEN-1:0]           result,
    output logic                                error
);

    logic [exec_pkg::REG_ADDR_W-1:0]    rs1_addr;
    logic [exec_pkg::REG_ADDR_W-1:0]    rs2_addr;
    logic [exec_pkg::REG_ADDR_W-1:0]    waddr;
    logic [exec_pkg::XLEN-1:0]          rs1_data;
    logic [exec_pkg::XLEN-1:0]          rs2_data;
    logic [exec_pkg::XLEN-1:0]          wdata;
    logic                               we;
    logic [exec_pkg::XLEN-1:0]          alu_a;
    logic [exec_pkg::XLEN-1:0]          alu_b;
    logic [exec_pkg::XLEN-1:0]          alu_result;
    exec_pkg::alu_op_e                  alu_op;
    logic                               alu_word;
    logic [exec_pkg::XLEN-1:0]          md_a;
    logic [exec_pkg::XLEN-1:0]          md_b;
    logic [exec_pkg::XLEN-1:0]          md_result;
    exec_pkg::alu_op_e                  md_op;
    logic                               md_word;
    logic                               start;
    logic                               done;

    exec_sequencer #(
        .REG_COUNT(REG_COUNT)
    ) u_seq (
        .clk(clk), .reset(reset),
        .req(req), .op(op), .word(word), .rd(rd), .rs1(rs1), .rs2(rs2),
        .use_imm(use_imm), .imm(imm),
        .ack(ack), .result(result), .error(error),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .we(we), .waddr(waddr), .wdata(wdata),
        .alu_a(alu_a), .alu_b(alu_b), .alu_op(alu_op), .alu_word(alu_word),
        .alu_result(alu_result),
        .start(start), .md_op(md_op), .md_word(md_word), .md_a(md_a), .md_b(md_b),
        .done(done), .md_result(md_result)
    );

    int_regfile #(
        .REG_COUNT(REG_COUNT)
    ) u_regfile (
        .clk(clk), .reset(reset),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .we(we), .waddr(waddr), .wdata(wdata),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    alu u_alu (
        .a(alu_a), .b(alu_b), .op(alu_op), .word(alu_word),
        .alu_result(alu_result)
    );

    muldiv_unit u_muldiv (
        .clk(clk), .reset(reset), .start(start),
        .op(md_op), .word(md_word), .a(md_a), .b(md_b),
        .done(done), .md_result(md_result)
    );

endmodule

`default_nettype wire

//--- include/exec_tb_vectors.svh
// each entry holds op, word, rd, rs1, rs2, use_imm, imm, expected result, expected error
// operand registers are loaded by adding an immediate to x0
task automatic load_vectors();
    push_vector(exec_pkg::OP_ADD,    0,  1,  0, 0, 1, 64'h5, 64'h5, 0);
    push_vector(exec_pkg::OP_ADD,    0,  2,  0, 0, 1, 64'hfffffffffffffffd,
                64'hfffffffffffffffd, 0);
    push_vector(exec_pkg::OP_ADD,    0,  3,  0, 0, 1, 64'h8000000000000000,
                64'h8000000000000000, 0);
    push_vector(exec_pkg::OP_ADD,    0,  4,  0, 0, 1, '1, 64'hffffffffffffffff, 0);
    push_vector(exec_pkg::OP_ADD,    0,  5,  0, 0, 1, 64'h7fffffff, 64'h7fffffff, 0);
    push_vector(exec_pkg::OP_ADD,    0,  6,  0, 0, 1, 64'h123456789abcdef0,
                64'h123456789abcdef0, 0);
    // x17 and x18 form a write-then-read chain
    push_vector(exec_pkg::OP_ADD,    0, 17,  1, 2, 0, 64'h0, 64'h2, 0);
    push_vector(exec_pkg::OP_ADD,    0, 18, 17, 0, 1, 64'h1, 64'h3, 0);
    push_vector(exec_pkg::OP_SUB,    0, 16,  1, 2, 0, 64'h0, 64'h8, 0);
    push_vector(exec_pkg::OP_SUB,    0, 16,  1, 0, 1, 64'h7, 64'hfffffffffffffffe, 0);
    push_vector(exec_pkg::OP_SLT,    0, 16,  2, 1, 0, 64'h0, 64'h1, 0);
    push_vector(exec_pkg::OP_SLTU,   0, 16,  2, 1, 0, 64'h0, 64'h0, 0);
    push_vector(exec_pkg::OP_SLT,    0, 16,  1, 3, 0, 64'h0, 64'h0, 0);
    push_vector(exec_pkg::OP_SLTU,   0, 16,  1, 3, 0, 64'h0, 64'h1, 0);
    push_vector(exec_pkg::OP_XOR,    0, 16,  6, 0, 1, 64'hffff0000ffff0000,
                64'hedcb56786543def0, 0);
    push_vector(exec_pkg::OP_OR,     0, 16,  6, 0, 1, 64'hf, 64'h123456789abcdeff, 0);
    push_vector(exec_pkg::OP_AND,    0, 16,  6, 0, 1, 64'hff00ff00ff00ff00,
                64'h120056009a00de00, 0);
    // shift amounts of 70 and 68 wrap to 6 and 4
    push_vector(exec_pkg::OP_SLL,    0, 16,  1, 0, 1, 64'h46, 64'h140, 0);
    push_vector(exec_pkg::OP_SRL,    0, 16,  3, 0, 1, 64'h3f, 64'h1, 0);
    push_vector(exec_pkg::OP_SRA,    0, 16,  3, 0, 1, 64'h4, 64'hf800000000000000, 0);
    push_vector(exec_pkg::OP_SRA,    0, 16,  2, 1, 0, 64'h0, 64'hffffffffffffffff, 0);
    push_vector(exec_pkg::OP_SRL,    0, 16,  4, 0, 1, 64'h44, 64'h0fffffffffffffff, 0);
    // word forms
    push_vector(exec_pkg::OP_ADD,    1, 16,  5, 0, 1, 64'h1, 64'hffffffff80000000, 0);
    push_vector(exec_pkg::OP_SUB,    1, 16,  0, 5, 0, 64'h0, 64'hffffffff80000001, 0);
    push_vector(exec_pkg::OP_SLL,    1, 16,  1, 0, 1, 64'h21, 64'ha, 0);
    push_vector(exec_pkg::OP_SRL,    1, 16,  4, 0, 1, 64'h4, 64'h0fffffff, 0);
    push_vector(exec_pkg::OP_SRA,    1, 16,  6, 0, 1, 64'h8, 64'hffffffffff9abcde, 0);
    push_vector(exec_pkg::OP_SRL,    1, 16,  6, 0, 1, 64'h0, 64'hffffffff9abcdef0, 0);
    // multiply and divide with the x19 result read back by the next entry
    push_vector(exec_pkg::OP_MUL,    0, 19,  1, 1, 0, 64'h0, 64'h19, 0);
    push_vector(exec_pkg::OP_ADD,    0, 20, 19, 0, 1, 64'h0, 64'h19, 0);
    push_vector(exec_pkg::OP_MUL,    0, 16,  1, 2, 0, 64'h0, 64'hfffffffffffffff1, 0);
    push_vector(exec_pkg::OP_MULH,   0, 16,  2, 1, 0, 64'h0, 64'hffffffffffffffff, 0);
    push_vector(exec_pkg::OP_MULH,   0, 16,  2, 2, 0, 64'h0, 64'h0, 0);
    push_vector(exec_pkg::OP_MULHU,  0, 16,  4, 4, 0, 64'h0, 64'hfffffffffffffffe, 0);
    push_vector(exec_pkg::OP_MULHSU, 0, 16,  2, 4, 0, 64'h0, 64'hfffffffffffffffd, 0);
    push_vector(exec_pkg::OP_MUL,    1, 16,  5, 0, 1, 64'h2, 64'hfffffffffffffffe, 0);
    push_vector(exec_pkg::OP_DIV,    0, 16,  2, 0, 1, 64'h2, 64'hffffffffffffffff, 0);
    push_vector(exec_pkg::OP_REM,    0, 16,  2, 0, 1, 64'h2, 64'hffffffffffffffff, 0);
    push_vector(exec_pkg::OP_DIVU,   0, 16,  4, 0, 1, 64'h10, 64'h0fffffffffffffff, 0);
    push_vector(exec_pkg::OP_REMU,   0, 16,  6, 0, 1, 64'h100, 64'hf0, 0);
    // divide by zero, then min / -1
    push_vector(exec_pkg::OP_DIV,    0, 16,  1, 0, 0, 64'h0, 64'hffffffffffffffff, 0);
    push_vector(exec_pkg::OP_REMU,   0, 16,  6, 0, 0, 64'h0, 64'h123456789abcdef0, 0);
    push_vector(exec_pkg::OP_DIV,    0, 16,  3, 4, 0, 64'h0, 64'h8000000000000000, 0);
    push_vector(exec_pkg::OP_REM,    0, 16,  3, 4, 0, 64'h0, 64'h0, 0);
    push_vector(exec_pkg::OP_DIVU,   1, 16,  4, 0, 1, 64'h2, 64'h7fffffff, 0);
    push_vector(exec_pkg::OP_REMU,   1, 16,  2, 0, 1, 64'h10, 64'hd, 0);
    push_vector(exec_pkg::OP_DIV,    1, 16,  2, 0, 1, '1, 64'h3, 0);
    push_vector(exec_pkg::OP_REM,    1, 16,  1, 0, 0, 64'h0, 64'h5, 0);
    // illegal word forms leave rd at its old value
    push_vector(exec_pkg::OP_MULH,   1,  1,  2, 2, 0, 64'h0, 64'h0, 1);
    push_vector(exec_pkg::OP_ADD,    0, 16,  1, 0, 1, 64'h0, 64'h5, 0);
    push_vector(exec_pkg::OP_XOR,    1,  2,  1, 1, 0, 64'h0, 64'h0, 1);
    push_vector(exec_pkg::OP_ADD,    0, 16,  2, 0, 1, 64'h0, 64'hfffffffffffffffd, 0);
    // x0 ignores writes
    push_vector(exec_pkg::OP_ADD,    0,  0,  1, 0, 1, 64'h50, 64'h55, 0);
    push_vector(exec_pkg::OP_ADD,    0, 16,  0, 0, 0, 64'h0, 64'h0, 0);
endtask

//--- verification/exec_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_tb;

    localparam int REG_COUNT      = 32;
    localparam int MD_MAX_LATENCY = 70;

    logic                               clk;
    logic                               reset;
    logic                               req;
    exec_pkg::alu_op_e                  op;
    logic                               word;
    logic [exec_pkg::REG_ADDR_W-1:0]    rd;
    logic [exec_pkg::REG_ADDR_W-1:0]    rs1;
    logic [exec_pkg::REG_ADDR_W-1:0]    rs2;
    logic                               use_imm;
    logic [exec_pkg::XLEN-1:0]          imm;
    logic                               ack;
    logic [exec_pkg::XLEN-1:0]          result;
    logic                               error;

    // vector table columns
    exec_pkg::alu_op_e                  v_op[$];
    logic                               v_word[$];
    logic [exec_pkg::REG_ADDR_W-1:0]    v_rd[$];
    logic [exec_pkg::REG_ADDR_W-1:0]    v_rs1[$];
    logic [exec_pkg::REG_ADDR_W-1:0]    v_rs2[$];
    logic                               v_use_imm[$];
    logic [exec_pkg::XLEN-1:0]          v_imm[$];
    logic [exec_pkg::XLEN-1:0]          v_result[$];
    logic                               v_error[$];

    int cycle_limit = 0;
    int cycles      = 0;
    int test_count  = 0;
    int check_count = 0;
    int fail_count  = 0;

    exec_top #(
        .REG_COUNT(REG_COUNT)
    ) uut (
        .clk(clk), .reset(reset), .req(req), .op(op), .word(word),
        .rd(rd), .rs1(rs1), .rs2(rs2), .use_imm(use_imm), .imm(imm),
        .ack(ack), .result(result), .error(error)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic push_vector(
        input exec_pkg::alu_op_e            t_op,
        input logic                         t_word,
        input int                           t_rd,
        input int                           t_rs1,
        input int                           t_rs2,
        input logic                         t_use_imm,
        input logic [exec_pkg::XLEN-1:0]    t_imm,
        input logic [exec_pkg::XLEN-1:0]    t_result,
        input logic                         t_error
    );
        v_op.push_back(t_op);
        v_word.push_back(t_word);
        v_rd.push_back(t_rd[exec_pkg::REG_ADDR_W-1:0]);
        v_rs1.push_back(t_rs1[exec_pkg::REG_ADDR_W-1:0]);
        v_rs2.push_back(t_rs2[exec_pkg::REG_ADDR_W-1:0]);
        v_use_imm.push_back(t_use_imm);
        v_imm.push_back(t_imm);
        v_result.push_back(t_result);
        v_error.push_back(t_error);
    endtask

`include "exec_tb_vectors.svh"

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            fail_count++;
            $display("FAIL t=%0t %s got=%h expected=%h", $time, name, got, exp);
        end
    endtask

    task automatic run_command(
        input exec_pkg::alu_op_e            c_op,
        input logic                         c_word,
        input logic [exec_pkg::REG_ADDR_W-1:0] c_rd,
        input logic [exec_pkg::REG_ADDR_W-1:0] c_rs1,
        input logic [exec_pkg::REG_ADDR_W-1:0] c_rs2,
        input logic                         c_use_imm,
        input logic [exec_pkg::XLEN-1:0]    c_imm,
        input logic [exec_pkg::XLEN-1:0]    exp_result,
        input logic                         exp_error
    );
        int                         waited;
        int                         hold;
        int                         fails_before;
        logic [exec_pkg::XLEN-1:0]  held;
        waited       = 0;
        fails_before = fail_count;
        test_count++;
        @(posedge clk);
        req     <= 1'b1;
        op      <= c_op;
        word    <= c_word;
        rd      <= c_rd;
        rs1     <= c_rs1;
        rs2     <= c_rs2;
        use_imm <= c_use_imm;
        imm     <= c_imm;
        do begin
            @(negedge clk);
            waited++;
        end while (!ack);
        check_value("result", result, exp_result);
        check_value("error", error, exp_error);
        // the first two falling edges come before and after the edge that samples req
        if (c_op < exec_pkg::OP_MUL || exp_error) begin
            check_value("ack latency", waited - 2, 2);
        end else if (waited - 2 > MD_MAX_LATENCY) begin
            fail_count++;
            $display("multiply/divide took %0d cycles, more than %0d",
                     waited - 2, MD_MAX_LATENCY);
        end
        // req stays up a few more cycles as back-pressure
        held = result;
        hold = $urandom_range(3, 0);
        repeat (hold) begin
            @(negedge clk);
            check_value("ack", ack, 1);
            check_value("result", result, held);
        end
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        check_value("ack", ack, 1);
        check_value("result", result, held);
        @(negedge clk);
        check_value("ack", ack, 0);
        check_value("error", error, 0);
        $display("test %0d %s%s: %s", test_count, c_op.name(), c_word ? " word" : "",
                 (fail_count == fails_before) ? "ok" : "mismatch");
    endtask

    // watchdog
    initial begin
        @(posedge clk);
        while (cycle_limit == 0 || cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the DUT stopped answering", cycles);
        $display("tests failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h0788_98a2));
        reset   = 1'b1;
        req     = 1'b0;
        op      = exec_pkg::OP_ADD;
        word    = 1'b0;
        rd      = '0;
        rs1     = '0;
        rs2     = '0;
        use_imm = 1'b0;
        imm     = '0;
        load_vectors();
        cycle_limit = (v_op.size() + REG_COUNT) * 80 + 100;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("ack", ack, 0);
        check_value("error", error, 0);
        check_value("result", result, 0);
        $display("reset state: %s", (fail_count == 0) ? "ok" : "mismatch");
        // every register reads zero after reset
        for (int n = 0; n < REG_COUNT; n++) begin
            run_command(exec_pkg::OP_ADD, 1'b0, '0, '0, n[exec_pkg::REG_ADDR_W-1:0],
                        1'b0, '0, '0, 1'b0);
        end
        for (int i = 0; i < v_op.size(); i++) begin
            run_command(v_op[i], v_word[i], v_rd[i], v_rs1[i], v_rs2[i],
                        v_use_imm[i], v_imm[i], v_result[i], v_error[i]);
        end
        $display("%0d commands, %0d checks, %0d errors", test_count, check_count,
                 fail_count);
        if (fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
src/exec_pkg.sv
src/int_regfile.sv
src/alu.sv
src/muldiv_unit.sv
src/exec_sequencer.sv
src/exec_top.sv
verification/exec_tb.sv

//--- Bender.yml
package:
  name: exec_stage

sources:
  - files:
      - src/exec_pkg.sv
      - src/int_regfile.sv
      - src/alu.sv
      - src/muldiv_unit.sv
      - src/exec_sequencer.sv
      - src/exec_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/exec_tb.sv
